// File: Bender.yml
package:
  name: spi_link

sources:
  - include_dirs:
      - .
    files:
      - spi_link_pkg.sv
      - spi_master.sv
      - spi_slave.sv
      - spi_link_check.sv
      - spi_link_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_spi_link.sv

// File: spi_link_check.sv
////////////////////////////////////////
// link self-test, pairs master and slave results
// counts transfers and mismatching pairs
////////////////////////////////////////
`default_nettype none

module spi_link_check (
	input	wire						sys_clk,
	input	wire						sys_rst_n,
	input	wire						start,			// request, may hit a busy master
	input	wire						m_done,
	input	wire						s_rx_valid,
	input	wire spi_link_pkg::byte_t	tx_byte,		// master sends
	input	wire spi_link_pkg::byte_t	m_rx_byte,		// master got
	input	wire spi_link_pkg::byte_t	s_rx_byte,		// slave got
	input	wire spi_link_pkg::byte_t	s_tx_byte,		// slave replies
	output	spi_link_pkg::cnt_t			xfer_count,
	output	spi_link_pkg::cnt_t			err_count
);

	import spi_link_pkg::*;

	logic		pend;						// transfer open, later starts ignored
	logic		m_seen;
	logic		s_seen;
	logic		pair;						// both sides in by this cycle
	logic		take;						// start that opens a transfer
	logic		mismatch;
	byte_t		tx_q, s_tx_q, m_rx_q, s_rx_q;
	byte_t		m_val;
	byte_t		s_val;

	assign pair		= (m_seen | m_done) & (s_seen | s_rx_valid);
	assign take		= start & (~pend | pair);
	assign m_val	= m_done ? m_rx_byte : m_rx_q;		// late side straight from pulse
	assign s_val	= s_rx_valid ? s_rx_byte : s_rx_q;
	assign mismatch	= (m_val != s_tx_q) | (s_val != tx_q);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			pend		<= 1'b0;
			m_seen		<= 1'b0;
			s_seen		<= 1'b0;
			xfer_count	<= '0;
			err_count	<= '0;
		end else begin
			pend <= take | (pend & ~pair);
			m_seen <= ~pair & (m_seen | m_done);
			s_seen <= ~pair & (s_seen | s_rx_valid);
			if (pair && xfer_count != '1)
				xfer_count <= xfer_count + 1'b1;		// saturates
			if (pair && mismatch && err_count != '1)
				err_count <= err_count + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take) begin
			tx_q	<= tx_byte;
			s_tx_q	<= s_tx_byte;
		end
		if (m_done)
			m_rx_q <= m_rx_byte;
		if (s_rx_valid)
			s_rx_q <= s_rx_byte;
	end

endmodule

`default_nettype wire

// File: spi_link_config.svh
////////////////////////////////////////
// spi link build constants, bus mode and widths
// include wherever a `SPI_ macro is used
////////////////////////////////////////
`ifndef SPI_LINK_CONFIG_SVH
`define SPI_LINK_CONFIG_SVH

// sclk idle level
`define SPI_CPOL	1'b1

// 0 samples on first edge of a bit, 1 on second edge
`define SPI_CPHA	1'b1

`define SPI_DATA_W	8		// bits per transfer

`define SPI_DIV_W	16		// width of clk_div_val

`endif

// File: spi_link_pkg.sv
////////////////////////////////////////
// shared types of the spi link
// import in the module body, scope in port lists
////////////////////////////////////////
`default_nettype none

`include "spi_link_config.svh"

package spi_link_pkg;

	typedef logic [`SPI_DATA_W-1:0] byte_t;		// one data byte
	typedef logic [15:0] cnt_t;					// saturating event count

	// master engine states
	typedef enum logic [2:0] {
		mst_idle		= 3'd0,		// waiting for start
		mst_sclk_wait	= 3'd1,		// half-period count
		mst_sclk_edge	= 3'd2,		// sclk toggles
		mst_last_half	= 3'd3,		// hold after 16th edge
		mst_ack			= 3'd4,		// m_done pulse
		mst_finish		= 3'd5		// cs_n back high
	} mst_state_t;

	// slave receiver states
	typedef enum logic [1:0] {
		slv_idle	= 2'd0,		// cs_n high or byte done
		slv_shift	= 2'd1,		// bits in flight
		slv_done	= 2'd2		// s_rx_valid pulse
	} slv_state_t;

endpackage

`default_nettype wire

// File: spi_link_top.sv
////////////////////////////////////////
// spi link top, master and slave with self-test
// both pin sets come out, loop closed outside
////////////////////////////////////////
`default_nettype none

`include "spi_link_config.svh"

module spi_link_top (
	input	wire							sys_clk,
	input	wire							sys_rst_n,
	input	wire							start,
	input	wire spi_link_pkg::byte_t		tx_byte,
	input	wire logic [`SPI_DIV_W-1:0]		clk_div_val,
	input	wire spi_link_pkg::byte_t		s_tx_byte,
	output	wire							m_cs_n,			// master pins
	output	wire							m_sclk,
	output	wire							m_mosi,
	input	wire							m_miso,
	input	wire							s_cs_n,			// slave pins
	input	wire							s_sclk,
	input	wire							s_mosi,
	output	wire							s_miso,
	output	wire							busy,
	output	wire							m_done,
	output	wire spi_link_pkg::byte_t		m_rx_byte,
	output	wire							s_rx_valid,
	output	wire spi_link_pkg::byte_t		s_rx_byte,
	output	wire spi_link_pkg::cnt_t		xfer_count,
	output	wire spi_link_pkg::cnt_t		err_count
);

	spi_master u_master (
		.sys_clk		(sys_clk),
		.sys_rst_n		(sys_rst_n),
		.start			(start),
		.tx_byte		(tx_byte),
		.clk_div_val	(clk_div_val),
		.m_miso			(m_miso),
		.m_cs_n			(m_cs_n),
		.m_sclk			(m_sclk),
		.m_mosi			(m_mosi),
		.busy			(busy),
		.m_done			(m_done),
		.m_rx_byte		(m_rx_byte)
	);

	spi_slave u_slave (
		.sys_clk		(sys_clk),
		.sys_rst_n		(sys_rst_n),
		.s_cs_n			(s_cs_n),
		.s_sclk			(s_sclk),
		.s_mosi			(s_mosi),
		.s_tx_byte		(s_tx_byte),
		.s_miso			(s_miso),
		.s_rx_valid		(s_rx_valid),
		.s_rx_byte		(s_rx_byte)
	);

	// sees raw start, drops those that hit a busy master
	spi_link_check u_check (
		.sys_clk		(sys_clk),
		.sys_rst_n		(sys_rst_n),
		.start			(start),
		.m_done			(m_done),
		.s_rx_valid		(s_rx_valid),
		.tx_byte		(tx_byte),
		.m_rx_byte		(m_rx_byte),
		.s_rx_byte		(s_rx_byte),
		.s_tx_byte		(s_tx_byte),
		.xfer_count		(xfer_count),
		.err_count		(err_count)
	);

endmodule

`default_nettype wire

// File: spi_master.sv
////////////////////////////////////////
// spi master engine, one byte each way per start
// sclk half-period is clk_div_val+1 sys_clk cycles
////////////////////////////////////////
`default_nettype none

`include "spi_link_config.svh"

module spi_master (
	input	wire							sys_clk,		// system clock
	input	wire							sys_rst_n,		// sync reset, active low
	input	wire							start,			// one-cycle request
	input	wire spi_link_pkg::byte_t		tx_byte,		// byte to send, with start
	input	wire logic [`SPI_DIV_W-1:0]		clk_div_val,	// half-period minus one, >= 3
	input	wire							m_miso,			// serial in
	output	logic							m_cs_n,			// chip select
	output	logic							m_sclk,			// serial clock
	output	logic							m_mosi,			// serial out
	output	logic							busy,			// start ignored while high
	output	logic							m_done,			// one-cycle done pulse
	output	spi_link_pkg::byte_t			m_rx_byte		// received byte
);

	import spi_link_pkg::*;

	localparam int edge_w		= $clog2(2 * `SPI_DATA_W);		// sclk edge counter width
	localparam int last_edge	= 2 * `SPI_DATA_W - 1;			// index of final toggle

	mst_state_t						state;
	logic [`SPI_DIV_W-1:0]			cnt_clk;		// cycles within half-period
	logic [`SPI_DIV_W-1:0]			div_last;		// wait ends here, edge cycle adds one
	logic [edge_w-1:0]				cnt_edge;		// toggles done so far
	byte_t							mosi_shift;
	byte_t							miso_shift;
	logic							accept;			// start taken this cycle
	logic							do_shift;		// mosi advances on this edge
	logic							do_sample;		// miso captured on this edge

	assign div_last		= clk_div_val - 1'b1;
	assign busy			= (state != mst_idle) && (state != mst_finish);	// free again in finish
	assign accept		= start && !busy;
	assign m_done		= (state == mst_ack);
	assign m_mosi		= mosi_shift[`SPI_DATA_W-1];		// msb first
	assign m_rx_byte	= miso_shift;

	// even edges lead a bit, odd edges trail it
	assign do_sample = (state == mst_sclk_edge) && (cnt_edge[0] == `SPI_CPHA);
	assign do_shift = (state == mst_sclk_edge) && (cnt_edge[0] != `SPI_CPHA) &&
		!(`SPI_CPHA == 1'b1 && cnt_edge == '0);		// cpha 1 holds msb through first edge

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= mst_idle;
		end else begin
			case (state)
				mst_idle, mst_finish:
					state <= accept ? mst_sclk_wait : mst_idle;
				mst_sclk_wait:
					if (cnt_clk == div_last)
						state <= mst_sclk_edge;
				mst_sclk_edge:
					if (cnt_edge == edge_w'(last_edge))
						state <= mst_last_half;
					else
						state <= mst_sclk_wait;
				mst_last_half:
					if (cnt_clk == clk_div_val)		// full half-period after last toggle
						state <= mst_ack;
				mst_ack:
					state <= mst_finish;
				default:
					state <= mst_idle;
			endcase
		end
	end

	// half-period timer, runs only while waiting
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cnt_clk <= '0;
		else if (state == mst_sclk_wait || state == mst_last_half)
			cnt_clk <= cnt_clk + 1'b1;
		else
			cnt_clk <= '0;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cnt_edge <= '0;
		else if (accept)
			cnt_edge <= '0;					// fresh transfer
		else if (state == mst_sclk_edge)
			cnt_edge <= cnt_edge + 1'b1;	// wraps to 0 after last edge
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			m_sclk <= `SPI_CPOL;
		else if (state == mst_idle)
			m_sclk <= `SPI_CPOL;			// park at idle level
		else if (state == mst_sclk_edge)
			m_sclk <= ~m_sclk;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			m_cs_n <= 1'b1;
		else if (accept)
			m_cs_n <= 1'b0;					// low one cycle after start
		else if (state == mst_ack)
			m_cs_n <= 1'b1;					// high in finish
	end

	always_ff @(posedge sys_clk) begin
		if (accept)
			mosi_shift <= tx_byte;
		else if (do_shift)
			mosi_shift <= {mosi_shift[`SPI_DATA_W-2:0], 1'b0};
	end

	// miso is stable here when clk_div_val >= 3
	always_ff @(posedge sys_clk) begin
		if (do_sample)
			miso_shift <= {miso_shift[`SPI_DATA_W-2:0], m_miso};
	end

endmodule

`default_nettype wire

// File: spi_slave.sv
////////////////////////////////////////
// oversampling spi slave on sys_clk
// pins pass two-flop synchronizers, reply loads at cs_n fall
////////////////////////////////////////
`default_nettype none

`include "spi_link_config.svh"

module spi_slave (
	input	wire						sys_clk,		// system clock
	input	wire						sys_rst_n,		// sync reset, active low
	input	wire						s_cs_n,			// chip select pin
	input	wire						s_sclk,			// serial clock pin
	input	wire						s_mosi,			// serial in pin
	input	wire spi_link_pkg::byte_t	s_tx_byte,		// reply byte
	output	logic						s_miso,			// serial out pin
	output	logic						s_rx_valid,		// one-cycle pulse
	output	spi_link_pkg::byte_t		s_rx_byte		// received byte
);

	import spi_link_pkg::*;

	localparam int bit_w = $clog2(`SPI_DATA_W);

	slv_state_t					state;
	logic [2:0]					cs_sync;		// two sync stages plus history
	logic [2:0]					sclk_sync;
	logic [1:0]					mosi_sync;		// aligned with sclk_sync[1]
	logic						cs_fall;
	logic						cs_rise;
	logic						sclk_tgl;		// any sclk edge
	logic						edge_odd;		// next edge trails its bit
	logic [bit_w-1:0]			bit_cnt;		// bits sampled
	logic						samp;
	logic						pres;			// drive next reply bit
	byte_t						rx_shift;
	byte_t						tx_shift;

	assign cs_fall	= cs_sync[2] & ~cs_sync[1];
	assign cs_rise	= ~cs_sync[2] & cs_sync[1];
	assign sclk_tgl	= sclk_sync[2] ^ sclk_sync[1];

	// leading edge samples for cpha 0, trailing for cpha 1
	assign samp = (state == slv_shift) && sclk_tgl && (edge_odd == `SPI_CPHA);
	assign pres = (state == slv_shift) && sclk_tgl && (edge_odd != `SPI_CPHA);

	assign s_rx_valid	= (state == slv_done);
	assign s_rx_byte	= rx_shift;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cs_sync		<= 3'b111;
			sclk_sync	<= {3{`SPI_CPOL}};
			mosi_sync	<= 2'b00;
		end else begin
			cs_sync		<= {cs_sync[1:0], s_cs_n};
			sclk_sync	<= {sclk_sync[1:0], s_sclk};
			mosi_sync	<= {mosi_sync[0], s_mosi};
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= slv_idle;
		end else if (cs_fall) begin
			state <= slv_shift;			// restart on every select
		end else begin
			case (state)
				slv_shift:
					if (cs_rise)
						state <= slv_idle;		// aborted, no pulse
					else if (samp && bit_cnt == bit_w'(`SPI_DATA_W - 1))
						state <= slv_done;
				slv_done:
					state <= slv_idle;
				default:
					state <= slv_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			edge_odd	<= 1'b0;
			bit_cnt		<= '0;
		end else if (cs_fall) begin
			edge_odd	<= 1'b0;
			bit_cnt		<= '0;
		end else begin
			if (state == slv_shift && sclk_tgl)
				edge_odd <= ~edge_odd;
			if (samp)
				bit_cnt <= bit_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (samp)
			rx_shift <= {rx_shift[`SPI_DATA_W-2:0], mosi_sync[1]};
	end

	// cpha 0 puts the msb out at select, cpha 1 waits for the first edge
	always_ff @(posedge sys_clk) begin
		if (cs_fall) begin
			if (`SPI_CPHA == 1'b0)
				tx_shift <= {s_tx_byte[`SPI_DATA_W-2:0], 1'b0};
			else
				tx_shift <= s_tx_byte;
		end else if (pres) begin
			tx_shift <= {tx_shift[`SPI_DATA_W-2:0], 1'b0};
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			s_miso <= 1'b0;
		else if (cs_fall && `SPI_CPHA == 1'b0)
			s_miso <= s_tx_byte[`SPI_DATA_W-1];
		else if (pres)
			s_miso <= tx_shift[`SPI_DATA_W-1];
	end

endmodule

`default_nettype wire

// File: tb_spi_link.sv
////////////////////////////////////////
// testbench for the spi link with pins looped back here
// random byte pairs, sclk timing, busy starts, mosi fault
////////////////////////////////////////
`default_nettype none

`include "spi_link_config.svh"

module tb_spi_link;

	import spi_link_pkg::*;

	localparam int clk_period	= 8;
	localparam int n_xfers		= 44;		// 20 + 20 + 2 + 2
	localparam int max_div		= 9;		// slowest divider used

	logic						sys_clk;
	logic						sys_rst_n;
	logic						start;
	byte_t						tx_byte;
	logic [`SPI_DIV_W-1:0]		clk_div_val;
	byte_t						s_tx_byte;
	logic						flip_mosi;		// fault on the mosi wire
	wire						m_cs_n;
	wire						m_sclk;
	wire						m_mosi;
	wire						s_miso;
	wire						busy;
	wire						m_done;
	wire						s_rx_valid;
	wire byte_t					m_rx_byte;
	wire byte_t					s_rx_byte;
	wire cnt_t					xfer_count;
	wire cnt_t					err_count;

	byte_t		exp_m_rx;			// reply the master should get
	byte_t		exp_s_rx;			// byte the slave should get
	int			exp_xfer;
	int			exp_err;
	int			errors;
	int			sclk_errors;		// timing failures of test 3
	int			sclk_frames;		// cs_n low periods seen
	int			done_cnt;
	int			valid_cnt;
	logic		prev_cs;
	logic		prev_sclk;
	int			run_len;			// cycles since last sclk or cs_n change
	int			tgl_cnt;

	// loop-back wiring with an optional inverted mosi
	spi_link_top uut (
		.sys_clk		(sys_clk),
		.sys_rst_n		(sys_rst_n),
		.start			(start),
		.tx_byte		(tx_byte),
		.clk_div_val	(clk_div_val),
		.s_tx_byte		(s_tx_byte),
		.m_cs_n			(m_cs_n),
		.m_sclk			(m_sclk),
		.m_mosi			(m_mosi),
		.m_miso			(s_miso),
		.s_cs_n			(m_cs_n),
		.s_sclk			(m_sclk),
		.s_mosi			(m_mosi ^ flip_mosi),
		.s_miso			(s_miso),
		.busy			(busy),
		.m_done			(m_done),
		.m_rx_byte		(m_rx_byte),
		.s_rx_valid		(s_rx_valid),
		.s_rx_byte		(s_rx_byte),
		.xfer_count		(xfer_count),
		.err_count		(err_count)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(clk_period / 2) sys_clk = ~sys_clk;
	end

	task automatic report_mismatch(input string sig, input int got, input int expected);
		$display("CHECK FAILED at %0t: %s got 0x%0h, expected 0x%0h", $time, sig, got, expected);
		errors++;
	endtask

	task automatic report_error(input string what);
		$display("ERROR at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic end_test(input int num, input string name, input int fails);
		if (fails == 0)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, fails);
	endtask

	// result bytes checked on each pulse
	always @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			done_cnt	<= 0;
			valid_cnt	<= 0;
		end else begin
			if (m_done) begin
				assert (m_rx_byte == exp_m_rx)
				else report_mismatch("m_rx_byte", m_rx_byte, exp_m_rx);
				done_cnt <= done_cnt + 1;
			end
			if (s_rx_valid) begin
				assert (s_rx_byte == exp_s_rx)
				else report_mismatch("s_rx_byte", s_rx_byte, exp_s_rx);
				valid_cnt <= valid_cnt + 1;
			end
		end
	end

	// sclk levels and toggle count within each cs_n low period
	always @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			prev_cs		<= 1'b1;
			prev_sclk	<= `SPI_CPOL;
			run_len		<= 0;
			tgl_cnt		<= 0;
			sclk_frames	<= 0;
		end else begin
			prev_cs		<= m_cs_n;
			prev_sclk	<= m_sclk;
			if (prev_cs && !m_cs_n) begin
				run_len <= 1;						// first level starts at select
				tgl_cnt <= 0;
			end else if (!m_cs_n && m_sclk != prev_sclk) begin
				assert (run_len == int'(clk_div_val) + 1)
				else begin
					report_mismatch("m_sclk level length", run_len, int'(clk_div_val) + 1);
					sclk_errors++;
				end
				run_len <= 1;
				tgl_cnt <= tgl_cnt + 1;
			end else begin
				run_len <= run_len + 1;
			end
			if (!prev_cs && m_cs_n) begin
				sclk_frames <= sclk_frames + 1;
				assert (tgl_cnt == 2 * `SPI_DATA_W && m_sclk == `SPI_CPOL)
				else begin
					report_mismatch("m_sclk toggles", tgl_cnt, 2 * `SPI_DATA_W);
					sclk_errors++;
				end
			end
		end
	end

	// one looped transfer with an optional start while busy
	task automatic run_transfer(input logic poke);
		byte_t		m_byte;
		byte_t		s_byte;
		int			done_ref;
		int			valid_ref;
		m_byte		= byte_t'($urandom);
		s_byte		= byte_t'($urandom);
		done_ref	= done_cnt;
		valid_ref	= valid_cnt;
		@(negedge sys_clk);
		tx_byte		= m_byte;
		s_tx_byte	= s_byte;					// held until the next transfer
		exp_m_rx	= s_byte;
		exp_s_rx	= flip_mosi ? ~m_byte : m_byte;
		start		= 1'b1;
		@(negedge sys_clk);
		start		= 1'b0;
		tx_byte		= byte_t'($urandom);		// master keeps its own copy
		if (poke) begin
			repeat (5) @(negedge sys_clk);
			assert (busy) else report_error("busy low in the middle of a transfer");
			start = 1'b1;						// must be ignored
			@(negedge sys_clk);
			start = 1'b0;
		end
		while (done_cnt == done_ref || valid_cnt == valid_ref)
			@(negedge sys_clk);
		@(negedge sys_clk);						// counts settle
		while (busy)
			@(negedge sys_clk);
		exp_xfer++;
		if (flip_mosi)
			exp_err++;
		assert (done_cnt - done_ref == 1)
		else report_mismatch("m_done pulses", done_cnt - done_ref, 1);
		assert (valid_cnt - valid_ref == 1)
		else report_mismatch("s_rx_valid pulses", valid_cnt - valid_ref, 1);
		assert (xfer_count == exp_xfer)
		else report_mismatch("xfer_count", xfer_count, exp_xfer);
		assert (err_count == exp_err)
		else report_mismatch("err_count", err_count, exp_err);
		repeat (3) @(negedge sys_clk);			// cs_n high a few cycles
	endtask

	initial begin
		int		mark;
		int		sclk_mark;
		void'($urandom(20958));
		sys_rst_n	= 1'b0;
		start		= 1'b0;
		tx_byte		= '0;
		s_tx_byte	= '0;
		clk_div_val	= 3;
		flip_mosi	= 1'b0;
		exp_m_rx	= '0;
		exp_s_rx	= '0;
		exp_xfer	= 0;
		exp_err		= 0;
		errors		= 0;
		sclk_errors	= 0;
		repeat (16) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		@(negedge sys_clk);

		mark = errors;
		assert (m_cs_n == 1'b1) else report_mismatch("m_cs_n", m_cs_n, 1);
		assert (m_sclk == `SPI_CPOL) else report_mismatch("m_sclk", m_sclk, `SPI_CPOL);
		assert (busy == 1'b0) else report_mismatch("busy", busy, 0);
		assert (xfer_count == 0) else report_mismatch("xfer_count", xfer_count, 0);
		assert (err_count == 0) else report_mismatch("err_count", err_count, 0);
		end_test(1, "reset state", errors - mark);

		mark = errors;
		sclk_mark = sclk_errors;
		repeat (20) run_transfer(1'b0);
		clk_div_val = 9;
		repeat (20) run_transfer(1'b0);
		end_test(2, "looped random pairs", (errors - mark) - (sclk_errors - sclk_mark));
		assert (sclk_frames == 40) else begin
			report_mismatch("cs_n low periods", sclk_frames, 40);
			sclk_errors++;
		end
		end_test(3, "sclk timing", sclk_errors - sclk_mark);

		mark = errors;
		clk_div_val = 5;
		repeat (2) run_transfer(1'b1);
		end_test(4, "start while busy", errors - mark);

		mark = errors;
		flip_mosi = 1'b1;
		run_transfer(1'b0);
		flip_mosi = 1'b0;
		run_transfer(1'b0);						// link clean again
		end_test(5, "inverted mosi", errors - mark);

		$display("transfers %0d, xfer_count %0d, err_count %0d, check errors %0d",
			exp_xfer, xfer_count, err_count, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// watchdog allows 40 half-periods per transfer at the slowest divider
	initial begin
		#((16 + n_xfers * 40 * (max_div + 1)) * clk_period);
		$display("timeout: the transfers did not finish within the time limit");
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
spi_link_pkg.sv
spi_master.sv
spi_slave.sv
spi_link_check.sv
spi_link_top.sv
tb_spi_link.sv
